/* all.f */
design/turfio_pkg.sv
design/turfio_regs.sv
design/surf_lane_fifo.sv
design/surf_event_merger.sv
design/turfio_datapath_top.sv
verification/turfio_assertions.sv
verification/tb_turfio.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the TURFIO datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_turfio -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_turfio 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verification/tb_turfio.sv */
`timescale 1ns/1ps

module tb_turfio;

    logic                                               init_clk;
    logic                                               rst_n;
    turfio_pkg::wb_req_t                                wb_req;
    turfio_pkg::wb_rsp_t                                wb_rsp;
    turfio_pkg::surf_byte_t [turfio_pkg::NUM_LANES-1:0] surf_in;
    logic [turfio_pkg::NUM_LANES-1:0]                   surf_ready;
    turfio_pkg::ev_byte_t                               ev_out;
    logic                                               ev_ready;

    // Scoreboard state with expected bytes as {data, lane, last}
    integer                           seed;
    string                            test_name;
    logic [11:0]                      exp_q [$];
    logic [turfio_pkg::NUM_LANES-1:0] cur_en;
    logic [turfio_pkg::NUM_LANES-1:0] cur_inv;
    int                               ev_total;
    logic [31:0]                      rdat;

    turfio_datapath_top turfio_datapath_top_inst (
        .init_clk     (init_clk),
        .rst_n_i      (rst_n),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .surf_i       (surf_in),
        .surf_ready_o (surf_ready),
        .ev_o         (ev_out),
        .ev_ready_i   (ev_ready)
    );

    initial begin
        init_clk = 1'b0;
        forever #50 init_clk = ~init_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s (%s): expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out in %s while waiting for %s", test_name, what);
        abort_run();
    endtask

    // Bound checker failures end the run at once
    always @(negedge init_clk) begin
        if (turfio_datapath_top_inst.turfio_assertions_inst.fail_cnt != 0) begin
            $display("Bound assertion failed during %s", test_name);
            abort_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////////////////////////

    task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rd_data);
        int waited;
        waited = 0;
        @(negedge init_clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        // Hold the request until ack
        @(negedge init_clk);
        while (!wb_rsp.ack) begin
            waited++;
            if (waited > 20) begin
                report_timeout("Wishbone ack");
            end
            @(negedge init_clk);
        end
        rd_data = wb_rsp.dat;
        wb_req  = '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] discard;
        wb_cycle(1'b1, adr, wdat, discard);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] rd_data);
        wb_cycle(1'b0, adr, 32'd0, rd_data);
    endtask

    // Masks change only between events
    task automatic set_masks(input logic [6:0] en, input logic [6:0] inv);
        wb_write(turfio_pkg::REG_LANE_EN, {25'd0, en});
        wb_write(turfio_pkg::REG_LANE_INV, {25'd0, inv});
        cur_en  = en;
        cur_inv = inv;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Lane stimulus and event collection
    //////////////////////////////////////////////////////////////////////

    task automatic send_packet(input int lane, input int len);
        logic [7:0] data;
        logic [7:0] flip;
        int         waited;
        flip = {8{cur_inv[lane]}};
        for (int i = 0; i < len; i++) begin
            data = 8'($random(seed));
            @(negedge init_clk);
            surf_in[lane].valid = 1'b1;
            surf_in[lane].data  = data;
            surf_in[lane].last  = (i == len - 1);
            waited = 0;
            while (!surf_ready[lane]) begin
                waited++;
                if (waited > 50) begin
                    report_timeout("lane ready");
                end
                @(negedge init_clk);
            end
            // Disabled lanes never reach the output
            if (cur_en[lane]) begin
                exp_q.push_back({data ^ flip, 3'(lane), 1'b0});
            end
        end
        @(negedge init_clk);
        surf_in[lane] = '0;
    endtask

    task automatic collect_event(input logic random_ready);
        int          waited;
        logic [31:0] coin;
        logic        rdy;
        waited = 0;
        while (exp_q.size() > 0) begin
            @(negedge init_clk);
            coin     = $random(seed);
            rdy      = random_ready ? coin[0] : 1'b1;
            ev_ready = rdy;
            // Byte moves on the coming rising edge
            if (ev_out.valid && rdy) begin
                check_equal("event byte", {20'd0, exp_q[0]},
                            {20'd0, ev_out.data, ev_out.lane, ev_out.last});
                void'(exp_q.pop_front());
                waited = 0;
            end else begin
                waited++;
                if (waited > 200) begin
                    report_timeout("event output");
                end
            end
        end
        @(negedge init_clk);
        ev_ready = 1'b0;
        check_equal("idle after event", 32'd0, {31'd0, ev_out.valid});
    endtask

    // One packet on every lane in ascending order and then a drain
    task automatic run_event(input logic random_ready);
        int          len;
        logic [11:0] tail;
        for (int lane = 0; lane < turfio_pkg::NUM_LANES; lane++) begin
            len = ($random(seed) & 15) + 1;
            send_packet(lane, len);
        end
        // Event last only on the final byte of the top enabled lane
        tail    = exp_q.pop_back();
        tail[0] = 1'b1;
        exp_q.push_back(tail);
        collect_event(random_ready);
        ev_total = ev_total + 1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed     = 32'heb3f_bdf5;
        rst_n    = 1'b0;
        wb_req   = '0;
        surf_in  = '0;
        ev_ready = 1'b0;
        ev_total = 0;
        cur_en   = 7'h7f;
        cur_inv  = 7'b010_1000;
        repeat (2) @(posedge init_clk);
        @(negedge init_clk);
        rst_n = 1'b1;

        test_name = "register identity";
        wb_read(turfio_pkg::REG_ID, rdat);
        check_equal("id", turfio_pkg::DEVICE_ID, rdat);
        wb_read(turfio_pkg::REG_VERSION, rdat);
        check_equal("version", turfio_pkg::FW_VERSION, rdat);
        wb_read(4'hA, rdat);
        check_equal("unmapped", 32'd0, rdat);

        test_name = "register write";
        wb_read(turfio_pkg::REG_LANE_EN, rdat);
        check_equal("lane_en reset", 32'h7f, rdat);
        wb_read(turfio_pkg::REG_LANE_INV, rdat);
        check_equal("lane_inv reset", 32'h28, rdat);
        wb_write(turfio_pkg::REG_LANE_EN, 32'h55);
        wb_read(turfio_pkg::REG_LANE_EN, rdat);
        check_equal("lane_en", 32'h55, rdat);
        wb_write(turfio_pkg::REG_LANE_INV, 32'h1a);
        wb_read(turfio_pkg::REG_LANE_INV, rdat);
        check_equal("lane_inv", 32'h1a, rdat);
        wb_write(turfio_pkg::REG_ID, 32'hdead_beef);
        wb_read(turfio_pkg::REG_ID, rdat);
        check_equal("id read-only", turfio_pkg::DEVICE_ID, rdat);

        test_name = "all lanes";
        set_masks(7'h7f, 7'b010_1000);
        repeat (2) run_event(1'b0);

        test_name = "disabled lanes";
        set_masks(7'b101_0110, 7'b011_0001);
        repeat (2) run_event(1'b0);

        test_name = "back-pressure";
        set_masks(7'h7f, 7'b100_1010);
        repeat (3) run_event(1'b1);
        set_masks(7'b100_0001, 7'b000_0001);
        repeat (2) run_event(1'b1);

        test_name = "event count";
        wb_read(turfio_pkg::REG_EV_COUNT, rdat);
        check_equal("events", ev_total, rdat);

        if (turfio_datapath_top_inst.turfio_assertions_inst.fail_cnt == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Bound assertion failed during %s", test_name);
            abort_run();
        end
    end

endmodule

/* verification/turfio_assertions.sv */
`timescale 1ns/1ps

module turfio_assertions (
    input logic                 init_clk,
    input logic                 rst_n_i,
    input turfio_pkg::wb_req_t  wb_req_i,
    input turfio_pkg::wb_rsp_t  wb_rsp_o,
    input turfio_pkg::ev_byte_t ev_o,
    input logic                 ev_ready_i
);

    // Fresh request not yet acked
    logic req_new;

    // Count of failed checks, watched from the testbench top
    int unsigned fail_cnt = 0;

    assign req_new = wb_req_i.cyc & wb_req_i.stb & ~wb_rsp_o.ack;

    //////////////////////////////////////////////////////////////////////
    // Wishbone handshake
    //////////////////////////////////////////////////////////////////////

    ack_after_req: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        req_new |=> wb_rsp_o.ack)
        else begin
            fail_cnt++;
            $error("Wishbone ack missing on the cycle after a request");
        end

    // Never two acks in a row
    ack_one_cycle: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        wb_rsp_o.ack |=> !wb_rsp_o.ack)
        else begin
            fail_cnt++;
            $error("Wishbone ack held for more than one cycle");
        end

    ack_needs_req: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        wb_rsp_o.ack |-> $past(req_new))
        else begin
            fail_cnt++;
            $error("Wishbone ack without a preceding request");
        end

    //////////////////////////////////////////////////////////////////////
    // Event output
    //////////////////////////////////////////////////////////////////////

    // Stalled byte holds every field
    ev_stable: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        (ev_o.valid && !ev_ready_i) |=> (ev_o.valid && $stable(ev_o)))
        else begin
            fail_cnt++;
            $error("Event output changed while stalled");
        end

    // Quiet bus and output right out of reset
    reset_idle: assert property (@(posedge init_clk)
        !rst_n_i |=> (!wb_rsp_o.ack && !ev_o.valid))
        else begin
            fail_cnt++;
            $error("Ack or event valid high after reset");
        end

endmodule

bind turfio_datapath_top turfio_assertions turfio_assertions_inst (
    .init_clk   (init_clk),
    .rst_n_i    (rst_n_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .ev_o       (ev_o),
    .ev_ready_i (ev_ready_i)
);

/* design/turfio_datapath_top.sv */
`timescale 1ns/1ps

module turfio_datapath_top (
    input  logic                                               init_clk,
    input  logic                                               rst_n_i,
    input  turfio_pkg::wb_req_t                                wb_req_i,
    output turfio_pkg::wb_rsp_t                                wb_rsp_o,
    input  turfio_pkg::surf_byte_t [turfio_pkg::NUM_LANES-1:0] surf_i,
    output logic [turfio_pkg::NUM_LANES-1:0]                   surf_ready_o,
    output turfio_pkg::ev_byte_t                               ev_o,
    input  logic                                               ev_ready_i
);

    // Register block to lanes and merger
    logic [turfio_pkg::NUM_LANES-1:0]                   lane_en;
    logic [turfio_pkg::NUM_LANES-1:0]                   lane_inv;
    // Merger back to register block
    logic                                               ev_done;

    // Lane buffers to merger and back
    turfio_pkg::surf_byte_t [turfio_pkg::NUM_LANES-1:0] lane_head;
    logic [turfio_pkg::NUM_LANES-1:0]                   lane_avail;
    logic [turfio_pkg::NUM_LANES-1:0]                   lane_pop;

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////

    turfio_regs turfio_regs_inst (
        .init_clk   (init_clk),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .ev_done_i  (ev_done),
        .lane_en_o  (lane_en),
        .lane_inv_o (lane_inv)
    );

    //////////////////////////////////////////////////////////////////////
    // One buffer per SURF lane
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < turfio_pkg::NUM_LANES; i++) begin : g_lane
        surf_lane_fifo surf_lane_fifo_inst (
            .init_clk    (init_clk),
            .rst_n_i     (rst_n_i),
            .lane_en_i   (lane_en[i]),
            .lane_inv_i  (lane_inv[i]),
            .in_i        (surf_i[i]),
            .in_ready_o  (surf_ready_o[i]),
            .pop_i       (lane_pop[i]),
            .head_o      (lane_head[i]),
            .pkt_avail_o (lane_avail[i])
        );
    end

    // Event assembly
    surf_event_merger surf_event_merger_inst (
        .init_clk     (init_clk),
        .rst_n_i      (rst_n_i),
        .lane_en_i    (lane_en),
        .lane_head_i  (lane_head),
        .lane_avail_i (lane_avail),
        .lane_pop_o   (lane_pop),
        .ev_o         (ev_o),
        .ev_ready_i   (ev_ready_i),
        .ev_done_o    (ev_done)
    );

endmodule

/* design/surf_event_merger.sv */
`timescale 1ns/1ps

module surf_event_merger (
    input  logic                                               init_clk,
    input  logic                                               rst_n_i,
    input  logic [turfio_pkg::NUM_LANES-1:0]                   lane_en_i,
    input  turfio_pkg::surf_byte_t [turfio_pkg::NUM_LANES-1:0] lane_head_i,
    input  logic [turfio_pkg::NUM_LANES-1:0]                   lane_avail_i,
    output logic [turfio_pkg::NUM_LANES-1:0]                   lane_pop_o,
    output turfio_pkg::ev_byte_t                               ev_o,
    input  logic                                               ev_ready_i,
    output logic                                               ev_done_o
);

    //////////////////////////////////////////////////////////////////////
    // Lane selection helpers
    //////////////////////////////////////////////////////////////////////

    // Lowest set lane at or above start
    function automatic logic [turfio_pkg::LANE_IDX_W-1:0] next_lane(
        input logic [turfio_pkg::NUM_LANES-1:0] mask,
        input int                               start
    );
        logic [turfio_pkg::LANE_IDX_W-1:0] idx;
        idx = '0;
        // Descending so the lowest match wins
        for (int i = turfio_pkg::NUM_LANES - 1; i >= 0; i--) begin
            if (mask[i] && i >= start) begin
                idx = turfio_pkg::LANE_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // Highest set lane
    function automatic logic [turfio_pkg::LANE_IDX_W-1:0] top_lane(
        input logic [turfio_pkg::NUM_LANES-1:0] mask
    );
        logic [turfio_pkg::LANE_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < turfio_pkg::NUM_LANES; i++) begin
            if (mask[i]) begin
                idx = turfio_pkg::LANE_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////////////////////////

    // High while an event is being forwarded
    logic                                  run_q;
    // Enable mask frozen at event start
    logic [turfio_pkg::NUM_LANES-1:0]      en_q;
    logic [turfio_pkg::LANE_IDX_W-1:0]     cur_q;
    logic [turfio_pkg::LANE_IDX_W-1:0]     last_lane_q;

    logic                                  all_ready;
    logic                                  start;
    logic                                  xfer;
    turfio_pkg::surf_byte_t                head;

    // Every enabled lane holds a whole packet
    assign all_ready = &(lane_avail_i | ~lane_en_i);
    // Nothing enabled, nothing to merge
    assign start     = ~run_q & (|lane_en_i) & all_ready;

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            run_q       <= 1'b0;
            en_q        <= '0;
            cur_q       <= '0;
            last_lane_q <= '0;
        end else if (start) begin
            run_q       <= 1'b1;
            en_q        <= lane_en_i;
            cur_q       <= next_lane(lane_en_i, 0);
            last_lane_q <= top_lane(lane_en_i);
        end else if (xfer && head.last) begin
            // End of this lane's packet
            if (cur_q == last_lane_q) begin
                run_q <= 1'b0;
            end else begin
                cur_q <= next_lane(en_q, int'(cur_q) + 1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output path
    //////////////////////////////////////////////////////////////////////

    // Head only moves on a pop, so a stalled byte stays put
    always_comb begin
        head       = lane_head_i[cur_q];
        ev_o.valid = run_q & head.valid;
        ev_o.data  = head.data;
        ev_o.lane  = cur_q;
        // Event ends with the highest enabled lane
        ev_o.last  = head.last & (cur_q == last_lane_q);
    end

    assign xfer = ev_o.valid & ev_ready_i;

    // Pop the lane currently being forwarded
    always_comb begin
        lane_pop_o = '0;
        lane_pop_o[cur_q] = xfer;
    end

    assign ev_done_o = xfer & ev_o.last;

endmodule

/* design/surf_lane_fifo.sv */
`timescale 1ns/1ps

module surf_lane_fifo (
    input  logic                   init_clk,
    input  logic                   rst_n_i,
    input  logic                   lane_en_i,
    input  logic                   lane_inv_i,
    input  turfio_pkg::surf_byte_t in_i,
    output logic                   in_ready_o,
    input  logic                   pop_i,
    output turfio_pkg::surf_byte_t head_o,
    output logic                   pkt_avail_o
);

    // Storage, data byte above the last flag
    logic [8:0]                          mem_q [0:turfio_pkg::LANE_FIFO_DEPTH-1];
    logic [turfio_pkg::LANE_PTR_W-1:0]   wr_ptr_q;
    logic [turfio_pkg::LANE_PTR_W-1:0]   rd_ptr_q;
    // One extra bit so full is distinct from empty
    logic [turfio_pkg::LANE_PTR_W:0]     fill_q;
    logic [turfio_pkg::PKT_CNT_W-1:0]    pkt_cnt_q;

    logic       full;
    logic       empty;
    logic       wr_en;
    logic       rd_en;
    logic       pkt_in;
    logic       pkt_out;
    logic [7:0] in_data;

    assign full  = (fill_q == turfio_pkg::LANE_FIFO_DEPTH);
    assign empty = (fill_q == '0);

    // Disabled lane swallows everything
    assign in_ready_o = ~lane_en_i | ~full;

    // Undo the board pair swap
    assign in_data = in_i.data ^ {8{lane_inv_i}};

    assign wr_en   = in_i.valid & lane_en_i & ~full;
    assign rd_en   = pop_i & ~empty;
    assign pkt_in  = wr_en & in_i.last;
    assign pkt_out = rd_en & mem_q[rd_ptr_q][0];

    //////////////////////////////////////////////////////////////////////
    // Circular buffer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= {in_data, in_i.last};
        end
    end

    // Pointers and counts; disabling a lane flushes it
    always_ff @(posedge init_clk) begin
        if (!rst_n_i || !lane_en_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            fill_q    <= '0;
            pkt_cnt_q <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Net change of fill level
            fill_q    <= fill_q + wr_en - rd_en;
            // Complete packets held
            pkt_cnt_q <= pkt_cnt_q + pkt_in - pkt_out;
        end
    end

    // Head reads straight from storage, visible the cycle after a write
    always_comb begin
        head_o.valid = ~empty;
        head_o.data  = mem_q[rd_ptr_q][8:1];
        head_o.last  = mem_q[rd_ptr_q][0];
    end

    assign pkt_avail_o = (pkt_cnt_q != '0);

endmodule

/* design/turfio_regs.sv */
`timescale 1ns/1ps

module turfio_regs (
    input  logic                                   init_clk,
    input  logic                                   rst_n_i,
    input  turfio_pkg::wb_req_t                    wb_req_i,
    output turfio_pkg::wb_rsp_t                    wb_rsp_o,
    input  logic                                   ev_done_i,
    output logic [turfio_pkg::NUM_LANES-1:0]       lane_en_o,
    output logic [turfio_pkg::NUM_LANES-1:0]       lane_inv_o
);

    //////////////////////////////////////////////////////////////////////
    // Bus handshake
    //////////////////////////////////////////////////////////////////////

    // New request: cyc and stb high, not already acked
    logic                                 req_new;
    logic                                 wr_new;
    logic                                 ack_q;
    logic [turfio_pkg::WB_DAT_W-1:0]      rd_mux;
    logic [turfio_pkg::WB_DAT_W-1:0]      rdat_q;

    // Control registers
    logic [turfio_pkg::NUM_LANES-1:0]     lane_en_q;
    logic [turfio_pkg::NUM_LANES-1:0]     lane_inv_q;
    logic [turfio_pkg::EV_CNT_W-1:0]      ev_cnt_q;

    assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr_new  = req_new & wb_req_i.we;

    // Ack one cycle after the request, for one cycle only
    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////////

    // Address decode, unmapped reads as zero
    always_comb begin
        rd_mux = '0;
        case (wb_req_i.adr)
            turfio_pkg::REG_ID:       rd_mux = turfio_pkg::DEVICE_ID;
            turfio_pkg::REG_VERSION:  rd_mux = turfio_pkg::FW_VERSION;
            turfio_pkg::REG_LANE_EN:  rd_mux[turfio_pkg::NUM_LANES-1:0] = lane_en_q;
            turfio_pkg::REG_LANE_INV: rd_mux[turfio_pkg::NUM_LANES-1:0] = lane_inv_q;
            turfio_pkg::REG_EV_COUNT: rd_mux[turfio_pkg::EV_CNT_W-1:0] = ev_cnt_q;
            default:                  rd_mux = '0;
        endcase
    end

    // Captured with the request, presented with ack
    always_ff @(posedge init_clk) begin
        if (req_new) begin
            rdat_q <= rd_mux;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write path and event count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            lane_en_q  <= turfio_pkg::LANE_EN_DEFAULT;
            lane_inv_q <= turfio_pkg::LANE_INV_DEFAULT;
        end else if (wr_new) begin
            // Only the two mask registers are writable
            if (wb_req_i.adr == turfio_pkg::REG_LANE_EN) begin
                lane_en_q <= wb_req_i.dat[turfio_pkg::NUM_LANES-1:0];
            end
            if (wb_req_i.adr == turfio_pkg::REG_LANE_INV) begin
                lane_inv_q <= wb_req_i.dat[turfio_pkg::NUM_LANES-1:0];
            end
        end
    end

    // Free-running, wraps
    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            ev_cnt_q <= '0;
        end else if (ev_done_i) begin
            ev_cnt_q <= ev_cnt_q + 1'b1;
        end
    end

    // Outputs
    always_comb begin
        wb_rsp_o.ack = ack_q;
        wb_rsp_o.dat = rdat_q;
    end

    assign lane_en_o  = lane_en_q;
    assign lane_inv_o = lane_inv_q;

endmodule

/* design/turfio_pkg.sv */
package turfio_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath sizing
    //////////////////////////////////////////////////////////////////////

    // SURF lanes on one TURFIO
    localparam int NUM_LANES       = 7;
    // Lane number carried with every merged byte
    localparam int LANE_IDX_W      = 3;
    // Bytes of storage per lane
    localparam int LANE_FIFO_DEPTH = 32;
    // Circular buffer pointer width
    localparam int LANE_PTR_W      = $clog2(LANE_FIFO_DEPTH);
    // Enough for a buffer full of one-byte packets
    localparam int PKT_CNT_W       = 6;

    //////////////////////////////////////////////////////////////////////
    // Control bus
    //////////////////////////////////////////////////////////////////////

    // Word address, 16 registers
    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;
    // Event counter wraps at this width
    localparam int EV_CNT_W = 16;

    // "TFIO" in ASCII
    localparam logic [31:0] DEVICE_ID  = 32'h5446_494F;
    // Date field zero, then major 0, minor 4, revision 3
    localparam logic [31:0] FW_VERSION = {16'h0000, 4'd0, 4'd4, 8'd3};

    // Lanes 3 and 5 have swapped pairs on the board
    localparam logic [NUM_LANES-1:0] LANE_INV_DEFAULT = 7'b010_1000;
    // Every lane takes part after reset
    localparam logic [NUM_LANES-1:0] LANE_EN_DEFAULT  = '1;

    // Register map
    localparam logic [WB_ADR_W-1:0] REG_ID       = 4'd0;
    localparam logic [WB_ADR_W-1:0] REG_VERSION  = 4'd1;
    localparam logic [WB_ADR_W-1:0] REG_LANE_EN  = 4'd2;
    localparam logic [WB_ADR_W-1:0] REG_LANE_INV = 4'd3;
    localparam logic [WB_ADR_W-1:0] REG_EV_COUNT = 4'd4;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////

    // Master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // Slave to master, dat valid with ack
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // One lane byte, input side and buffer head
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } surf_byte_t;

    // Merged event byte, tagged with its source lane
    typedef struct packed {
        logic                  valid;
        logic [7:0]            data;
        logic [LANE_IDX_W-1:0] lane;
        logic                  last;
    } ev_byte_t;

endpackage
